// File: common/frame_buf_macros.svh
//------------------------------
// Sizing constants for the frame buffer.
// FIFO depth must be a power of two equal to 2**FB_PTR_W.
// FB_LEN_W must hold the value FB_FIFO_DEPTH.
//------------------------------
`ifndef FRAME_BUF_MACROS_SVH
`define FRAME_BUF_MACROS_SVH

// Byte width on both sides of the buffer.
`define FB_DATA_W 8

// FIFO entries and pointer width.
`define FB_FIFO_DEPTH 16
`define FB_PTR_W 4

// Frame lengths run 1..16, so 5 bits.
`define FB_LEN_W 5

// Pending frame lengths held by the reader.
`define FB_LENQ_DEPTH 16

`endif

// File: common/frame_buf_pkg.sv
//------------------------------
// Shared types for the frame buffer.
// Widths follow the macros header.
//------------------------------
`default_nettype none

`include "frame_buf_macros.svh"

package frame_buf_pkg;

    // One data byte.
    typedef logic [`FB_DATA_W-1:0] fb_byte_t;

    // One frame length, 1 to FB_FIFO_DEPTH.
    typedef logic [`FB_LEN_W-1:0] fb_len_t;

    // Writer FSM states.
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_FRAME,
        WR_DISCARD
    } wr_state_t;

    // Reader FSM states.
    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_t;

endpackage

`default_nettype wire

// File: byte_fifo/byte_fifo.sv
//------------------------------
// Byte FIFO with active-low strobes.
// Writes when full and reads when empty are ignored.
// rd_data is registered and only moves on a read strobe.
// clr is synchronous and wins over both strobes.
//------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "frame_buf_macros.svh"

module byte_fifo
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     clr,
    input  wire                     rd_n,
    input  wire                     wr_n,
    input  frame_buf_pkg::fb_byte_t wr_data,
    output frame_buf_pkg::fb_byte_t rd_data,
    output logic                    full,
    output logic                    empty
);

    // Depth in count width.
    localparam logic [`FB_PTR_W:0] DEPTH = `FB_FIFO_DEPTH;

    //------------------------------
    // Storage and pointers
    //------------------------------
    frame_buf_pkg::fb_byte_t mem [`FB_FIFO_DEPTH];

    logic [`FB_PTR_W-1:0] wr_ptr;
    logic [`FB_PTR_W-1:0] rd_ptr;

    // Occupancy, one bit wider than the pointers.
    logic [`FB_PTR_W:0] count;

    // Qualified strobes.
    logic do_wr;
    logic do_rd;

    assign do_wr = !wr_n && !full && !clr;
    assign do_rd = !rd_n && !empty && !clr;

    // Flags come straight from the count.
    // Same-cycle read and write leave them steady.
    assign full  = (count == DEPTH);
    assign empty = (count == '0);

    //------------------------------
    // Data path
    //------------------------------

    // Memory write.
    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Registered read data.
    always_ff @(posedge clk)
    begin
        if (!rd_n)
        begin
            rd_data <= mem[rd_ptr];
        end
    end

    //------------------------------
    // Pointers and count
    //------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (clr)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // Pointers wrap naturally at the power-of-two depth.
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            // Up on write, down on read, hold on both.
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/frame_writer.sv
//------------------------------
// Input side FSM.
// One byte per in_valid, no back-pressure.
// A byte while full drops the whole buffer and the rest of its frame.
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module frame_writer
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  frame_buf_pkg::fb_byte_t in_byte,
    input  wire                     in_last,
    input  wire                     fifo_full,
    output logic                    fifo_wr_n,
    output frame_buf_pkg::fb_byte_t fifo_wr_data,
    output logic                    fifo_clr,
    output logic                    frame_done,
    output frame_buf_pkg::fb_len_t  frame_len,
    output logic                    overflow
);

    frame_buf_pkg::wr_state_t state;

    // Bytes written so far in the current frame.
    frame_buf_pkg::fb_len_t len_cnt;
    frame_buf_pkg::fb_len_t len_next;

    logic accept;
    logic ovf;
    logic ovf_q;

    //------------------------------
    // Strobe decode
    //------------------------------

    // Byte goes into the FIFO.
    assign accept = in_valid && !fifo_full && (state != frame_buf_pkg::WR_DISCARD);

    // Byte hits a full FIFO.
    assign ovf = in_valid && fifo_full && (state != frame_buf_pkg::WR_DISCARD);

    // Write strobe follows in_valid in the same cycle.
    assign fifo_wr_n    = !accept;
    assign fifo_wr_data = in_byte;

    // Length including the byte being accepted.
    assign len_next = (state == frame_buf_pkg::WR_FRAME) ?
                      len_cnt + 1'b1 : frame_buf_pkg::fb_len_t'(1);

    // Clear and overflow share one registered pulse.
    assign fifo_clr = ovf_q;
    assign overflow = ovf_q;

    //------------------------------
    // FSM
    //------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state      <= frame_buf_pkg::WR_IDLE;
            len_cnt    <= '0;
            frame_done <= 1'b0;
            ovf_q      <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            ovf_q      <= ovf;
            case (state)
                frame_buf_pkg::WR_IDLE,
                frame_buf_pkg::WR_FRAME:
                begin
                    if (accept)
                    begin
                        len_cnt <= len_next;
                        if (in_last)
                        begin
                            frame_done <= 1'b1;
                            state      <= frame_buf_pkg::WR_IDLE;
                        end
                        else
                        begin
                            state <= frame_buf_pkg::WR_FRAME;
                        end
                    end
                    else if (ovf)
                    begin
                        // Dropped byte may itself end the frame.
                        len_cnt <= '0;
                        state   <= in_last ? frame_buf_pkg::WR_IDLE
                                           : frame_buf_pkg::WR_DISCARD;
                    end
                end
                frame_buf_pkg::WR_DISCARD:
                begin
                    // Drop through the next last marker.
                    if (in_valid && in_last)
                    begin
                        state <= frame_buf_pkg::WR_IDLE;
                    end
                end
                default:
                begin
                    state <= frame_buf_pkg::WR_IDLE;
                end
            endcase
        end
    end

    // Length travels with frame_done.
    always_ff @(posedge clk)
    begin
        if (accept && in_last)
        begin
            frame_len <= len_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/frame_reader.sv
//------------------------------
// Output side FSM with a queue of frame lengths.
// Reads only complete frames, so the FIFO never runs dry mid burst.
// No output back-pressure. flush drops all queued lengths.
//------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "frame_buf_macros.svh"

module frame_reader
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     frame_done,
    input  frame_buf_pkg::fb_len_t  frame_len,
    output logic                    fifo_rd_n,
    input  frame_buf_pkg::fb_byte_t fifo_rd_data,
    output logic                    out_valid,
    output frame_buf_pkg::fb_byte_t out_byte,
    output logic                    out_last
);

    localparam int QPTR_W = $clog2(`FB_LENQ_DEPTH);
    localparam logic [QPTR_W:0] QDEPTH = `FB_LENQ_DEPTH;

    //------------------------------
    // Length queue
    //------------------------------
    frame_buf_pkg::fb_len_t lenq [`FB_LENQ_DEPTH];

    logic [QPTR_W-1:0] q_wr_ptr;
    logic [QPTR_W-1:0] q_rd_ptr;
    logic [QPTR_W:0]   q_count;

    frame_buf_pkg::fb_len_t q_head;

    logic q_push;
    logic q_pop;
    logic q_nonempty;
    logic q_full;

    //------------------------------
    // Burst control
    //------------------------------
    frame_buf_pkg::rd_state_t state;

    // Bytes still to strobe, including the current one.
    frame_buf_pkg::fb_len_t remaining;

    logic rd_strobe;
    logic last_strobe;

    // Output pipeline, one cycle behind the strobe.
    logic valid_q;
    logic last_q;

    assign q_head     = lenq[q_rd_ptr];
    assign q_nonempty = (q_count != '0);
    assign q_full     = (q_count == QDEPTH);

    // Lost only if the queue is full.
    assign q_push = frame_done && !q_full;

    // Head length is taken when a burst starts.
    assign q_pop = (state == frame_buf_pkg::RD_IDLE) && q_nonempty && !flush;

    // Strobe decode.
    always_comb
    begin
        rd_strobe   = 1'b0;
        last_strobe = 1'b0;
        case (state)
            frame_buf_pkg::RD_IDLE:
            begin
                rd_strobe   = q_nonempty && !flush;
                last_strobe = (q_head == frame_buf_pkg::fb_len_t'(1));
            end
            frame_buf_pkg::RD_BURST:
            begin
                rd_strobe   = !flush;
                last_strobe = (remaining == frame_buf_pkg::fb_len_t'(1));
            end
            default:
            begin
                rd_strobe   = 1'b0;
                last_strobe = 1'b0;
            end
        endcase
    end

    assign fifo_rd_n = !rd_strobe;

    // FIFO data is already registered.
    assign out_byte  = fifo_rd_data;
    assign out_valid = valid_q;
    assign out_last  = last_q;

    // Queue storage.
    always_ff @(posedge clk)
    begin
        if (q_push)
        begin
            lenq[q_wr_ptr] <= frame_len;
        end
    end

    // Queue pointers. Flush wins over a same-cycle push.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end
        else if (flush)
        begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end
        else
        begin
            if (q_push)
            begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (q_pop)
            begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            case ({q_push, q_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    //------------------------------
    // Burst FSM
    //------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= frame_buf_pkg::RD_IDLE;
            remaining <= '0;
            valid_q   <= 1'b0;
            last_q    <= 1'b0;
        end
        else if (flush)
        begin
            // Abort burst and drop pending output.
            state     <= frame_buf_pkg::RD_IDLE;
            remaining <= '0;
            valid_q   <= 1'b0;
            last_q    <= 1'b0;
        end
        else
        begin
            valid_q <= rd_strobe;
            last_q  <= rd_strobe && last_strobe;
            case (state)
                frame_buf_pkg::RD_IDLE:
                begin
                    // One-byte frame finishes in the start cycle.
                    if (q_pop && !last_strobe)
                    begin
                        remaining <= q_head - 1'b1;
                        state     <= frame_buf_pkg::RD_BURST;
                    end
                end
                frame_buf_pkg::RD_BURST:
                begin
                    remaining <= remaining - 1'b1;
                    if (last_strobe)
                    begin
                        state <= frame_buf_pkg::RD_IDLE;
                    end
                end
                default:
                begin
                    state <= frame_buf_pkg::RD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/frame_buffer_top.sv
//------------------------------
// Frame buffer top level.
// Holds up to 16 bytes. Overflow drops the whole buffer.
// First output byte 3 cycles after the last input byte when idle.
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module frame_buffer_top
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  frame_buf_pkg::fb_byte_t in_byte,
    input  wire                     in_last,
    output logic                    out_valid,
    output frame_buf_pkg::fb_byte_t out_byte,
    output logic                    out_last,
    output logic                    overflow,
    output logic                    buf_empty
);

    // Writer to FIFO.
    logic                    fifo_wr_n;
    frame_buf_pkg::fb_byte_t fifo_wr_data;
    logic                    fifo_clr;
    logic                    full;

    // Writer to reader.
    logic                    frame_done;
    frame_buf_pkg::fb_len_t  frame_len;

    // Reader to FIFO.
    logic                    fifo_rd_n;
    frame_buf_pkg::fb_byte_t rd_data;

    frame_writer u_frame_writer
    (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_byte      (in_byte),
        .in_last      (in_last),
        .fifo_full    (full),
        .fifo_wr_n    (fifo_wr_n),
        .fifo_wr_data (fifo_wr_data),
        .fifo_clr     (fifo_clr),
        .frame_done   (frame_done),
        .frame_len    (frame_len),
        .overflow     (overflow)
    );

    byte_fifo u_byte_fifo
    (
        .clk     (clk),
        .rst     (rst),
        .clr     (fifo_clr),
        .rd_n    (fifo_rd_n),
        .wr_n    (fifo_wr_n),
        .wr_data (fifo_wr_data),
        .rd_data (rd_data),
        .full    (full),
        .empty   (buf_empty)
    );

    // Overflow clear also flushes the reader.
    frame_reader u_frame_reader
    (
        .clk          (clk),
        .rst          (rst),
        .flush        (fifo_clr),
        .frame_done   (frame_done),
        .frame_len    (frame_len),
        .fifo_rd_n    (fifo_rd_n),
        .fifo_rd_data (rd_data),
        .out_valid    (out_valid),
        .out_byte     (out_byte),
        .out_last     (out_last)
    );

endmodule

`default_nettype wire

// File: dv/frame_buffer_tb.sv
//------------------------------
// Testbench for frame_buffer_top.
// Inputs move 1 ns after the rising edge, outputs are sampled on the falling edge.
// Oversized frames are only sent into a drained buffer.
//------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "frame_buf_macros.svh"

module frame_buffer_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int N_SINGLE     = 8;
    localparam int N_B2B        = 10;
    localparam int B2B_MAX_LEN  = 8;
    localparam int IDLE_GAP     = 3;
    localparam int DRAIN_LIMIT  = 60;
    localparam int OUT_LATENCY  = 3;
    localparam int N_VALID      = 3;
    localparam int OVF_SHORT    = `FB_FIFO_DEPTH + 1;
    localparam int OVF_LONG     = `FB_FIFO_DEPTH + 4;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    frame_buf_pkg::fb_byte_t in_byte;
    logic                    in_last;
    logic                    out_valid;
    frame_buf_pkg::fb_byte_t out_byte;
    logic                    out_last;
    logic                    overflow;
    logic                    buf_empty;

    // Expected output stream from the reference model.
    frame_buf_pkg::fb_byte_t exp_bytes [$];
    logic                    exp_lasts [$];
    frame_buf_pkg::fb_byte_t exp_b;
    logic                    exp_l;

    // Frame lengths drawn before the first test.
    int single_lens [N_SINGLE];
    int b2b_lens [N_B2B];
    int valid_lens [N_VALID];

    int          cyc = 0;
    int          limit_cycles = 0;
    int          total_bytes = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    string       test_name = "none";
    int          ovf_count = 0;
    int          ovf_base = 0;
    int          exp_ovf = 0;
    int          lat_req = 0;
    int          lat_ack = 0;
    int          last_in_cyc = 0;
    int unsigned seed_ret;

    //------------------------------
    // Clock, DUT and watchdog
    //------------------------------
    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    frame_buffer_top u_frame_buffer_top
    (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_byte   (in_byte),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_byte  (out_byte),
        .out_last  (out_last),
        .overflow  (overflow),
        .buf_empty (buf_empty)
    );

    // Cycle count and run limit.
    always @(posedge clk)
    begin
        cyc = cyc + 1;
        if (limit_cycles > 0 && cyc > limit_cycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    //------------------------------
    // Reference model and checks
    //------------------------------

    // A frame that fits comes back unchanged.
    // A longer one gives one overflow and no output.
    function automatic void model_frame(input frame_buf_pkg::fb_byte_t data [$]);
        if (data.size() > `FB_FIFO_DEPTH)
            exp_ovf = exp_ovf + 1;
        else
        begin
            foreach (data[i])
            begin
                exp_bytes.push_back(data[i]);
                exp_lasts.push_back(i == data.size() - 1);
            end
        end
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        test_errors++;
        $display("ERROR in %s: %s", test_name, msg);
    endtask

    task automatic check_byte(input frame_buf_pkg::fb_byte_t expected,
                              input frame_buf_pkg::fb_byte_t actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            test_errors++;
            $display("MISMATCH %s out_byte expected 0x%02h actual 0x%02h",
                     test_name, expected, actual);
        end
    endtask

    task automatic check_last(input logic expected, input logic actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            test_errors++;
            $display("MISMATCH %s out_last expected %b actual %b", test_name, expected, actual);
        end
    endtask

    task automatic check_overflow(input int expected, input int actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            test_errors++;
            $display("MISMATCH %s overflow pulses expected %0d actual %0d",
                     test_name, expected, actual);
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            test_errors++;
            $display("MISMATCH %s first out_valid latency expected %0d actual %0d",
                     test_name, expected, actual);
        end
    endtask

    task automatic check_level(input string what, input logic expected, input logic actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            test_errors++;
            $display("MISMATCH %s %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    // Compares outputs on every falling edge.
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (overflow)
                ovf_count = ovf_count + 1;
            // Last input byte of a frame whose latency is measured.
            if (in_valid && in_last && lat_req != lat_ack)
                last_in_cyc = cyc;
            if (out_last && !out_valid)
                report_failure("out_last was high while out_valid was low");
            if (out_valid)
            begin
                if (exp_bytes.size() == 0)
                    report_failure($sformatf("unexpected output byte 0x%02h", out_byte));
                else
                begin
                    exp_b = exp_bytes.pop_front();
                    exp_l = exp_lasts.pop_front();
                    check_byte(exp_b, out_byte);
                    check_last(exp_l, out_last);
                end
                if (lat_req != lat_ack)
                begin
                    check_latency(OUT_LATENCY, cyc - last_in_cyc);
                    lat_ack = lat_req;
                end
            end
        end
    end

    //------------------------------
    // Stimulus tasks
    //------------------------------
    task automatic send_frame(input int len);
        frame_buf_pkg::fb_byte_t data [$];
        for (int i = 0; i < len; i++)
            data.push_back(frame_buf_pkg::fb_byte_t'($urandom));
        model_frame(data);
        for (int i = 0; i < len; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid = 1'b1;
            in_byte  = data[i];
            in_last  = (i == len - 1);
        end
    endtask

    task automatic go_idle(input int cycles);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
        in_last  = 1'b0;
        repeat (cycles) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Waits a bounded time for the expected stream to empty.
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_bytes.size() != 0 || !buf_empty || out_valid) && waited < DRAIN_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (exp_bytes.size() != 0)
        begin
            report_failure($sformatf("%0d expected output bytes never arrived",
                                     exp_bytes.size()));
            exp_bytes.delete();
            exp_lasts.delete();
        end
        check_level("buf_empty", 1'b1, buf_empty);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        exp_ovf     = 0;
        ovf_base    = ovf_count;
    endtask

    task automatic end_test();
        check_overflow(exp_ovf, ovf_count - ovf_base);
        tests_run++;
        $display("Test %s done with %0d errors", test_name, test_errors);
    endtask

    //------------------------------
    // Test sequence
    //------------------------------
    initial
    begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_byte  = '0;
        in_last  = 1'b0;
        seed_ret = $urandom(32'h691f_80c2);

        // Draw every length up front to size the run limit.
        for (int i = 0; i < N_SINGLE; i++)
        begin
            single_lens[i] = $urandom_range(`FB_FIFO_DEPTH, 1);
            total_bytes += single_lens[i];
        end
        // Pairs of one-byte frames between short random ones.
        for (int i = 0; i < N_B2B; i++)
        begin
            if (i % 4 < 2)
                b2b_lens[i] = 1;
            else
                b2b_lens[i] = $urandom_range(B2B_MAX_LEN, 1);
            total_bytes += b2b_lens[i];
        end
        for (int i = 0; i < N_VALID; i++)
        begin
            valid_lens[i] = $urandom_range(`FB_FIFO_DEPTH, 1);
            total_bytes += valid_lens[i];
        end
        total_bytes += OVF_SHORT + OVF_LONG;
        limit_cycles = total_bytes * 4 + 200;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        start_test("reset_values");
        @(posedge clk);
        #DRIVE_DELAY;
        check_level("buf_empty", 1'b1, buf_empty);
        check_level("out_valid", 1'b0, out_valid);
        check_level("out_last", 1'b0, out_last);
        check_level("overflow", 1'b0, overflow);
        end_test();

        // One frame at a time with latency measured.
        start_test("single_frames");
        for (int i = 0; i < N_SINGLE; i++)
        begin
            lat_req = lat_req + 1;
            send_frame(single_lens[i]);
            go_idle(IDLE_GAP);
            wait_drain();
        end
        end_test();

        // No idle cycle between frames.
        start_test("back_to_back");
        for (int i = 0; i < N_B2B; i++)
            send_frame(b2b_lens[i]);
        go_idle(IDLE_GAP);
        wait_drain();
        end_test();

        // Last byte itself hits the full FIFO.
        start_test("overflow_17");
        send_frame(OVF_SHORT);
        go_idle(IDLE_GAP);
        wait_drain();
        send_frame(valid_lens[0]);
        go_idle(IDLE_GAP);
        wait_drain();
        end_test();

        // Tail of the frame is discarded.
        start_test("overflow_discard");
        send_frame(OVF_LONG);
        go_idle(IDLE_GAP);
        wait_drain();
        send_frame(valid_lens[1]);
        go_idle(IDLE_GAP);
        wait_drain();
        end_test();

        // Whole frame is stored before the first read completes.
        start_test("drain_empty");
        send_frame(valid_lens[2]);
        go_idle(1);
        check_level("buf_empty", 1'b0, buf_empty);
        wait_drain();
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/frame_buf_pkg.sv
byte_fifo/byte_fifo.sv
rtl/frame_writer.sv
rtl/frame_reader.sv
rtl/frame_buffer_top.sv
dv/frame_buffer_tb.sv

// File: Makefile
# Verilator flow for the frame buffer.
# Any variable below can be overridden, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= frame_buffer_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All checks passed
JOBS       ?= 0
VFLAGS     ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator exit code.
run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed, log in $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
